//--- src/fdc_pkg.sv
package fdc_pkg;

	// ========================================
	// main status register
	// ========================================
	localparam int MSR_D0B = 0;  // drive 0 seeking
	localparam int MSR_D1B = 1;  // drive 1 seeking
	localparam int MSR_CB  = 4;  // command in progress
	localparam int MSR_DIO = 6;  // 1 = controller to host
	localparam int MSR_RQM = 7;

	// drive geometry and step rate
	localparam logic [7:0] CYL_COUNT = 8'd80;
	localparam logic [3:0] SRT_RESET = 4'd4;

	// result bytes with the drive in bit 0 of ST0
	localparam logic [7:0] ST0_SEEK_END  = 8'h20;
	localparam logic [7:0] ST0_ABNORMAL  = 8'hE8;
	localparam logic [7:0] RES_INVALID   = 8'h80;
	localparam logic [7:0] RES_IDLE_READ = 8'hFF;

	// ========================================
	// commands and states
	// ========================================
	typedef enum logic [4:0] {
		OP_SPECIFY     = 5'd3,
		OP_SENSE_DRIVE = 5'd4,
		OP_RECAL       = 5'd7,
		OP_SENSE_INT   = 5'd8,
		OP_SEEK        = 5'd15
	} fdc_opcode_e;

	typedef enum logic [3:0] {
		ST_IDLE,
		ST_SPECIFY1,
		ST_SPECIFY2,
		ST_RECAL,
		ST_SEEK_DRV,
		ST_SEEK_CYL,
		ST_SENSE_INT,
		ST_SENSE_INT_PCN,
		ST_SENSE_DRV,
		ST_SENSE_DRV_RD,
		ST_INVALID
	} fdc_state_e;

	typedef struct packed {
		logic       wr;    // one cycle per host write
		logic       rd;    // one cycle per host read
		logic [7:0] data;
	} host_bus_t;

	typedef struct packed {
		logic       start;
		logic       recal;
		logic [7:0] cyl;
	} seek_req_t;

	typedef struct packed {
		logic       busy;
		logic       int_pending;
		logic       seek_ok;
		logic [7:0] pcn;
	} drive_stat_t;

endpackage

//--- src/fdc_host_port.sv
`timescale 1ns/1ps

module fdc_host_port
	import fdc_pkg::*;
(
	input  logic       i_clk_sys,
	input  logic       i_reset,
	input  logic       i_a0,
	input  logic       i_n_rd,
	input  logic       i_n_wr,
	input  logic [7:0] i_din,
	input  logic [7:0] i_status,
	input  logic [7:0] i_data,
	output host_bus_t  o_bus,
	output logic [7:0] o_dout
);

	logic       r_n_rd, r_n_wr;  // registered bus controls
	logic       p_n_rd, p_n_wr;  // previous sample
	logic       r_a0;
	logic [7:0] r_din;
	logic [7:0] data_q;
	logic       wr_stb, rd_stb;

	always_ff @(posedge i_clk_sys) begin
		if (i_reset) begin
			r_n_rd <= 1'b1;
			r_n_wr <= 1'b1;
			p_n_rd <= 1'b1;
			p_n_wr <= 1'b1;
			wr_stb <= 1'b0;
			rd_stb <= 1'b0;
		end else begin
			r_n_rd <= i_n_rd;
			r_n_wr <= i_n_wr;
			p_n_rd <= r_n_rd;
			p_n_wr <= r_n_wr;
			// falling edge of the strobe line, other line idle, data port only
			wr_stb <= p_n_wr & ~r_n_wr & r_n_rd & r_a0;
			rd_stb <= p_n_rd & ~r_n_rd & r_n_wr & r_a0;
		end
	end

	// address and byte follow the controls
	always_ff @(posedge i_clk_sys) begin
		r_a0   <= i_a0;
		r_din  <= i_din;
		data_q <= r_din;
	end

	assign o_bus = '{wr: wr_stb, rd: rd_stb, data: data_q};

	assign o_dout = i_a0 ? i_data : i_status;  // a0=0 reads the MSR

	a_one_strobe: assert property (@(posedge i_clk_sys) disable iff (i_reset)
		!(wr_stb && rd_stb))
		else $error("host port: read and write strobe together");

endmodule

//--- src/fdc_cmd_fsm.sv
`timescale 1ns/1ps

module fdc_cmd_fsm
	import fdc_pkg::*;
(
	input  logic        i_clk_sys,
	input  logic        i_reset,
	input  host_bus_t   i_bus,
	input  logic [1:0]  i_available,
	input  drive_stat_t i_drv0,
	input  drive_stat_t i_drv1,
	output seek_req_t   o_req0,
	output seek_req_t   o_req1,
	output logic [1:0]  o_int_clr,
	output logic [3:0]  o_srt,
	output logic [7:0]  o_status,
	output logic [7:0]  o_data
);

	fdc_state_e  state, cmd_state;
	fdc_opcode_e opcode;
	logic [1:0]  req_start;
	logic        req_recal;
	logic [7:0]  req_cyl;
	logic        drv_sel;   // drive of the current command
	logic        head_sel;
	logic [3:0]  srt;
	logic [7:0]  data_reg;
	logic [7:0]  sel_pcn;
	logic        int_any, int_drv;
	logic        int_ok;
	logic [7:0]  st0, st3;
	logic        dio;

	// ========================================
	// command decode
	// ========================================
	assign opcode = fdc_opcode_e'(i_bus.data[4:0]);

	always_comb begin
		cmd_state = ST_INVALID;
		if (i_bus.data[7:5] == 3'b000) begin  // no MT/MFM/SK on these
			case (opcode)
				OP_SPECIFY:     cmd_state = ST_SPECIFY1;
				OP_SENSE_DRIVE: cmd_state = ST_SENSE_DRV;
				OP_RECAL:       cmd_state = ST_RECAL;
				OP_SENSE_INT:   cmd_state = ST_SENSE_INT;
				OP_SEEK:        cmd_state = ST_SEEK_DRV;
				default:        cmd_state = ST_INVALID;
			endcase
		end
	end

	// drive 0 wins when both have an interrupt
	assign int_any = i_drv0.int_pending | i_drv1.int_pending;
	assign int_drv = ~i_drv0.int_pending;
	assign int_ok  = i_drv0.int_pending ? i_drv0.seek_ok : i_drv1.seek_ok;
	assign st0     = (int_ok ? ST0_SEEK_END : ST0_ABNORMAL) | {7'd0, int_drv};

	assign sel_pcn = drv_sel ? i_drv1.pcn : i_drv0.pcn;
	assign st3 = {2'b00, i_available[drv_sel], sel_pcn == 8'd0, 1'b0, head_sel, 1'b0, drv_sel};

	// ========================================
	// state machine
	// ========================================
	always_ff @(posedge i_clk_sys) begin
		if (i_reset) begin
			state     <= ST_IDLE;
			srt       <= SRT_RESET;
			req_start <= 2'b00;
			o_int_clr <= 2'b00;
		end else begin
			req_start <= 2'b00;
			o_int_clr <= 2'b00;
			case (state)
				ST_IDLE:
					if (i_bus.wr) state <= cmd_state;
				ST_SPECIFY1:
					if (i_bus.wr) begin
						srt   <= i_bus.data[7:4];  // head unload time ignored
						state <= ST_SPECIFY2;
					end
				ST_SPECIFY2:
					if (i_bus.wr) state <= ST_IDLE;  // head load time, not used
				ST_RECAL:
					if (i_bus.wr) begin
						req_start[i_bus.data[0]] <= 1'b1;
						state <= ST_IDLE;
					end
				ST_SEEK_DRV:
					if (i_bus.wr) state <= ST_SEEK_CYL;
				ST_SEEK_CYL:
					if (i_bus.wr) begin
						req_start[drv_sel] <= 1'b1;
						state <= ST_IDLE;
					end
				ST_SENSE_INT:
					if (i_bus.rd) state <= int_any ? ST_SENSE_INT_PCN : ST_IDLE;
				ST_SENSE_INT_PCN:
					if (i_bus.rd) begin
						o_int_clr[drv_sel] <= 1'b1;
						state <= ST_IDLE;
					end
				ST_SENSE_DRV:
					if (i_bus.wr) state <= ST_SENSE_DRV_RD;
				ST_SENSE_DRV_RD, ST_INVALID:
					if (i_bus.rd) state <= ST_IDLE;
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// parameter bytes and the data register
	always_ff @(posedge i_clk_sys) begin
		if (i_bus.wr) begin
			case (state)
				ST_RECAL: begin
					drv_sel   <= i_bus.data[0];
					req_recal <= 1'b1;
				end
				ST_SEEK_DRV:  drv_sel <= i_bus.data[0];
				ST_SEEK_CYL: begin
					req_recal <= 1'b0;
					req_cyl   <= i_bus.data;
				end
				ST_SENSE_DRV: begin
					drv_sel  <= i_bus.data[0];
					head_sel <= i_bus.data[2];
				end
				default: ;
			endcase
		end
		if (i_bus.rd) begin
			case (state)
				ST_IDLE:    data_reg <= RES_IDLE_READ;
				ST_INVALID: data_reg <= RES_INVALID;
				ST_SENSE_INT: begin
					data_reg <= int_any ? st0 : RES_INVALID;
					drv_sel  <= int_drv;
				end
				ST_SENSE_INT_PCN: data_reg <= sel_pcn;
				ST_SENSE_DRV_RD:  data_reg <= st3;
				default: ;
			endcase
		end
	end

	assign o_req0 = '{start: req_start[0], recal: req_recal, cyl: req_cyl};
	assign o_req1 = '{start: req_start[1], recal: req_recal, cyl: req_cyl};
	assign o_srt  = srt;
	assign o_data = data_reg;

	// result phase drives the bus
	assign dio = state inside {ST_SENSE_INT, ST_SENSE_INT_PCN, ST_SENSE_DRV_RD, ST_INVALID};

	always_comb begin
		o_status          = 8'h00;
		o_status[MSR_RQM] = 1'b1;  // always ready, no back-pressure
		o_status[MSR_DIO] = dio;
		o_status[MSR_CB]  = state != ST_IDLE;
		o_status[MSR_D0B] = i_drv0.busy;
		o_status[MSR_D1B] = i_drv1.busy;
	end

	a_state_legal: assert property (@(posedge i_clk_sys) disable iff (i_reset)
		state inside {ST_IDLE, ST_SPECIFY1, ST_SPECIFY2, ST_RECAL, ST_SEEK_DRV, ST_SEEK_CYL,
			ST_SENSE_INT, ST_SENSE_INT_PCN, ST_SENSE_DRV, ST_SENSE_DRV_RD, ST_INVALID})
		else $error("cmd fsm: illegal state");

endmodule

//--- src/fdc_step_timer.sv
`timescale 1ns/1ps

module fdc_step_timer #(
	parameter int CYCLES_PER_MS = 4000
) (
	input  logic       i_clk_sys,
	input  logic       i_reset,
	input  logic       i_start,
	input  logic [3:0] i_srt,
	output logic       o_done
);

	logic [$clog2(CYCLES_PER_MS + 1)-1:0] ms_cnt;  // cycles left in this ms
	logic [3:0] step_cnt;  // counts up from srt to 15
	logic       running;

	always_ff @(posedge i_clk_sys) begin
		if (i_reset) begin
			running <= 1'b0;
			o_done  <= 1'b0;
		end else begin
			o_done <= 1'b0;
			if (i_start) begin
				running  <= 1'b1;
				ms_cnt   <= CYCLES_PER_MS[$bits(ms_cnt)-1:0];
				step_cnt <= i_srt;
			end else if (running) begin
				if (ms_cnt != '0) begin
					ms_cnt <= ms_cnt - 1'b1;
				end else if (step_cnt != 4'hF) begin
					step_cnt <= step_cnt + 4'd1;  // next millisecond
					ms_cnt   <= CYCLES_PER_MS[$bits(ms_cnt)-1:0];
				end else begin
					running <= 1'b0;
					o_done  <= 1'b1;
				end
			end
		end
	end

	a_done_pulse: assert property (@(posedge i_clk_sys) disable iff (i_reset)
		o_done |=> !o_done)
		else $error("step timer: done held high");

endmodule

//--- src/fdc_drive_track.sv
`timescale 1ns/1ps

module fdc_drive_track
	import fdc_pkg::*;
#(
	parameter int CYCLES_PER_MS = 4000
) (
	input  logic        i_clk_sys,
	input  logic        i_reset,
	input  seek_req_t   i_req,
	input  logic        i_int_clr,
	input  logic [3:0]  i_srt,
	input  logic        i_ready,
	input  logic        i_motor,
	input  logic        i_fast,
	output drive_stat_t o_stat
);

	logic [7:0] pcn;  // present cylinder
	logic [7:0] ncn;  // new cylinder
	logic [7:0] target;
	logic       target_ok;
	logic       busy, int_pending, seek_ok;
	logic       stepping;  // waiting out one head step
	logic       step_start, step_done;

	assign target    = i_req.recal ? 8'd0 : i_req.cyl;
	assign target_ok = (target == 8'd0) || (i_ready && i_motor && target < CYL_COUNT);

	// a new request takes priority over a step
	assign step_start = busy && !stepping && pcn != ncn && !i_fast && !i_req.start;

	fdc_step_timer #(
		.CYCLES_PER_MS(CYCLES_PER_MS)
	) i_fdc_step_timer (
		.i_clk_sys(i_clk_sys),
		.i_reset  (i_reset),
		.i_start  (step_start),
		.i_srt    (i_srt),
		.o_done   (step_done)
	);

	always_ff @(posedge i_clk_sys) begin
		if (i_reset) begin
			pcn         <= 8'd0;
			ncn         <= 8'd0;
			busy        <= 1'b0;
			int_pending <= 1'b0;
			seek_ok     <= 1'b0;
			stepping    <= 1'b0;
		end else begin
			if (i_int_clr) int_pending <= 1'b0;
			if (step_done) stepping <= 1'b0;

			if (i_req.start) begin
				if (target_ok) begin
					ncn         <= target;
					busy        <= 1'b1;
					int_pending <= 1'b0;
				end else begin
					// seek error leaves the head in place
					int_pending <= 1'b1;
					seek_ok     <= 1'b0;
				end
			end else if (busy && !stepping) begin
				if (pcn == ncn) begin
					busy        <= 1'b0;
					int_pending <= 1'b1;
					seek_ok     <= i_ready;
				end else if (i_fast) begin
					pcn <= ncn;  // jump straight there
				end else begin
					pcn      <= (pcn > ncn) ? pcn - 8'd1 : pcn + 8'd1;
					stepping <= 1'b1;
				end
			end
		end
	end

	assign o_stat = '{busy: busy, int_pending: int_pending, seek_ok: seek_ok, pcn: pcn};

	a_pcn_range: assert property (@(posedge i_clk_sys) disable iff (i_reset)
		pcn < CYL_COUNT)
		else $error("drive track: pcn %0d out of range", pcn);

endmodule

//--- src/fdc_top.sv
`timescale 1ns/1ps

module fdc_top
	import fdc_pkg::*;
#(
	parameter int CYCLES_PER_MS = 4000
) (
	input  logic       i_clk_sys,
	input  logic       i_reset,
	input  logic       i_a0,
	input  logic       i_n_rd,
	input  logic       i_n_wr,
	input  logic [7:0] i_din,
	output logic [7:0] o_dout,
	input  logic [1:0] i_ready,
	input  logic [1:0] i_motor,
	input  logic [1:0] i_available,
	input  logic       i_fast
);

	host_bus_t   bus;
	seek_req_t   req0, req1;
	drive_stat_t drv0, drv1;
	logic [1:0]  int_clr;
	logic [3:0]  srt;
	logic [7:0]  status, data;

	fdc_host_port i_fdc_host_port (
		.i_clk_sys(i_clk_sys),
		.i_reset  (i_reset),
		.i_a0     (i_a0),
		.i_n_rd   (i_n_rd),
		.i_n_wr   (i_n_wr),
		.i_din    (i_din),
		.i_status (status),
		.i_data   (data),
		.o_bus    (bus),
		.o_dout   (o_dout)
	);

	fdc_cmd_fsm i_fdc_cmd_fsm (
		.i_clk_sys  (i_clk_sys),
		.i_reset    (i_reset),
		.i_bus      (bus),
		.i_available(i_available),
		.i_drv0     (drv0),
		.i_drv1     (drv1),
		.o_req0     (req0),
		.o_req1     (req1),
		.o_int_clr  (int_clr),
		.o_srt      (srt),
		.o_status   (status),
		.o_data     (data)
	);

	// ========================================
	// one tracker per drive
	// ========================================
	fdc_drive_track #(.CYCLES_PER_MS(CYCLES_PER_MS)) i_fdc_drive_track0 (
		.i_clk_sys(i_clk_sys),
		.i_reset  (i_reset),
		.i_req    (req0),
		.i_int_clr(int_clr[0]),
		.i_srt    (srt),
		.i_ready  (i_ready[0]),
		.i_motor  (i_motor[0]),
		.i_fast   (i_fast),
		.o_stat   (drv0)
	);

	fdc_drive_track #(.CYCLES_PER_MS(CYCLES_PER_MS)) i_fdc_drive_track1 (
		.i_clk_sys(i_clk_sys),
		.i_reset  (i_reset),
		.i_req    (req1),
		.i_int_clr(int_clr[1]),
		.i_srt    (srt),
		.i_ready  (i_ready[1]),
		.i_motor  (i_motor[1]),
		.i_fast   (i_fast),
		.o_stat   (drv1)
	);

endmodule

//--- bench/fdc_tb_tasks.svh
`ifndef FDC_TB_TASKS_SVH
`define FDC_TB_TASKS_SVH

// ========================================
// reference functions
// ========================================
function automatic logic [31:0] xorshift32(input logic [31:0] x);
	logic [31:0] s;
	s = x;
	s = s ^ (s << 13);
	s = s ^ (s >> 17);
	s = s ^ (s << 5);
	return s;
endfunction

// target 0 is always allowed and others need a spinning ready drive
function automatic logic seek_valid(input logic [7:0] cyl, input logic rdy, input logic mot);
	return (cyl == 8'd0) || (rdy && mot && cyl < 8'd80);
endfunction

function automatic logic [7:0] st0_ref(input logic ok, input logic drive);
	return (ok ? 8'h20 : 8'hE8) | {7'd0, drive};
endfunction

function automatic logic [7:0] st3_ref(input logic avail, input logic [7:0] pcn,
	input logic head, input logic drive);
	logic [7:0] st3;
	st3 = 8'h00;
	st3[5] = avail;
	st3[4] = (pcn == 8'd0);  // track 0
	st3[2] = head;
	st3[0] = drive;
	return st3;
endfunction

// ========================================
// bus access
// ========================================
task automatic bus_write(input logic addr, input logic [7:0] value);
	@(negedge clk_sys);
	a0   = addr;
	din  = value;
	n_wr = 1'b0;
	repeat (4) @(negedge clk_sys);  // hold
	n_wr = 1'b1;
	repeat (4) @(negedge clk_sys);  // idle gap
endtask

task automatic bus_read(input logic addr, output logic [7:0] value);
	@(negedge clk_sys);
	a0   = addr;
	n_rd = 1'b0;
	repeat (4) @(negedge clk_sys);
	value = dout;  // data register settled after the 3rd edge
	n_rd = 1'b1;
	repeat (4) @(negedge clk_sys);
endtask

task automatic queue_check(input logic [7:0] got, input logic [7:0] exp, input string what);
	got_q.push_back(got);
	exp_q.push_back(exp);
	what_q.push_back(what);
endtask

task automatic wait_not_busy(input int drive);
	logic [7:0] msr;
	int polls;
	polls = 0;
	bus_read(1'b0, msr);
	while (msr[drive] && polls < 200) begin
		bus_read(1'b0, msr);
		polls++;
	end
	assert (!msr[drive])
	else begin
		timeout_count++;
		$display("timeout at %0t: drive %0d still seeking after %0d status polls",
			$time, drive, polls);
	end
endtask

`endif

//--- bench/fdc_tb.sv
`timescale 1ns/1ps

module fdc_tb;

	logic        clk_sys;
	logic        reset;
	logic        a0, n_rd, n_wr;
	logic [7:0]  din;
	logic [7:0]  dout;
	logic [1:0]  ready, motor, available;
	logic        fast;

	logic [7:0]  got_q[$];
	logic [7:0]  exp_q[$];
	string       what_q[$];
	int          mismatch_count = 0;
	int          timeout_count = 0;
	logic [7:0]  exp_pcn[2];  // model of each drive head
	logic        exp_ok[2];
	logic [31:0] rng;

	fdc_top #(.CYCLES_PER_MS(8)) i_fdc_top (
		.i_clk_sys  (clk_sys),
		.i_reset    (reset),
		.i_a0       (a0),
		.i_n_rd     (n_rd),
		.i_n_wr     (n_wr),
		.i_din      (din),
		.o_dout     (dout),
		.i_ready    (ready),
		.i_motor    (motor),
		.i_available(available),
		.i_fast     (fast)
	);

	`include "fdc_tb_tasks.svh"

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// ========================================
	// command sequences
	// ========================================
	task automatic seek_drive(input logic drive, input logic [7:0] cyl);
		bus_write(1'b1, 8'h0F);
		bus_write(1'b1, {7'd0, drive});
		bus_write(1'b1, cyl);
		if (seek_valid(cyl, ready[drive], motor[drive])) begin
			exp_pcn[drive] = cyl;
			exp_ok[drive]  = ready[drive];
		end else begin
			exp_ok[drive] = 1'b0;  // pcn unchanged
		end
	endtask

	task automatic recal_drive(input logic drive);
		bus_write(1'b1, 8'h07);
		bus_write(1'b1, {7'd0, drive});
		exp_pcn[drive] = 8'd0;
		exp_ok[drive]  = ready[drive];
	endtask

	task automatic sense_interrupt(input logic drive);
		logic [7:0] v;
		bus_write(1'b1, 8'h08);
		bus_read(1'b1, v);
		queue_check(v, st0_ref(exp_ok[drive], drive), "sense interrupt ST0");
		bus_read(1'b1, v);
		queue_check(v, exp_pcn[drive], "sense interrupt PCN");
	endtask

	task automatic sense_drive_check(input logic drive, input logic head);
		logic [7:0] v;
		bus_write(1'b1, 8'h04);
		bus_write(1'b1, {5'd0, head, 1'b0, drive});
		bus_read(1'b1, v);
		queue_check(v, st3_ref(available[drive], exp_pcn[drive], head, drive), "sense drive ST3");
	endtask

	// compare each queued read
	initial begin : compare_proc
		logic [7:0] g, e;
		string w;
		forever begin
			@(posedge clk_sys);
			while (got_q.size() > 0) begin
				g = got_q.pop_front();
				e = exp_q.pop_front();
				w = what_q.pop_front();
				assert (g == e)
				else begin
					mismatch_count++;
					$display("Mismatch at %0t: %s read %02h, expected %02h", $time, w, g, e);
				end
			end
		end
	end

	initial begin : stimulus
		logic [7:0] v;
		logic [7:0] cyl;
		int drain;
		reset     = 1'b1;
		a0        = 1'b0;
		n_rd      = 1'b1;
		n_wr      = 1'b1;
		din       = 8'h00;
		ready     = 2'b11;
		motor     = 2'b11;
		available = 2'b11;
		fast      = 1'b0;
		rng       = 32'd12;
		exp_pcn   = '{8'd0, 8'd0};
		exp_ok    = '{1'b0, 1'b0};
		repeat (16) @(negedge clk_sys);
		reset = 1'b0;

		bus_read(1'b0, v);
		queue_check(v, 8'h80, "status after reset");
		bus_read(1'b1, v);
		queue_check(v, 8'hFF, "data read in idle");

		bus_write(1'b1, 8'h1F);  // no such opcode
		bus_read(1'b0, v);
		queue_check(v, 8'hD0, "status in invalid result");
		bus_read(1'b1, v);
		queue_check(v, 8'h80, "invalid command result");
		bus_read(1'b0, v);
		queue_check(v, 8'h80, "status after invalid");

		// specify with step rate 14 in the high nibble
		bus_write(1'b1, 8'h03);
		bus_write(1'b1, 8'hE0);
		bus_write(1'b1, 8'h02);
		seek_drive(1'b0, 8'd5);
		wait_not_busy(0);
		sense_interrupt(1'b0);
		recal_drive(1'b0);
		bus_read(1'b0, v);
		queue_check({7'd0, v[0]}, 8'h01, "D0B during recalibrate");
		wait_not_busy(0);
		sense_interrupt(1'b0);

		fast = 1'b1;
		repeat (6) begin
			rng = xorshift32(rng);
			cyl = 8'(rng % 80);
			seek_drive(1'b1, cyl);
			wait_not_busy(1);
			sense_interrupt(1'b1);
		end

		seek_drive(1'b1, 8'd90);  // past the last cylinder
		wait_not_busy(1);
		sense_interrupt(1'b1);
		motor[1] = 1'b0;
		seek_drive(1'b1, 8'd40);
		wait_not_busy(1);
		sense_interrupt(1'b1);
		bus_write(1'b1, 8'h08);
		bus_read(1'b1, v);
		queue_check(v, 8'h80, "sense interrupt with nothing pending");
		motor[1] = 1'b1;

		available = 2'b00;
		sense_drive_check(1'b1, 1'b1);
		available = 2'b10;
		sense_drive_check(1'b1, 1'b1);
		seek_drive(1'b1, 8'd0);
		wait_not_busy(1);
		sense_interrupt(1'b1);
		sense_drive_check(1'b1, 1'b1);
		available = 2'b01;
		sense_drive_check(1'b1, 1'b1);

		drain = 0;
		while (got_q.size() > 0 && drain < 100) begin
			@(negedge clk_sys);
			drain++;
		end
		assert (got_q.size() == 0)
		else begin
			timeout_count++;
			$display("comparison queue still holds %0d reads at the end", got_q.size());
		end
		$display("errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
		if (mismatch_count == 0 && timeout_count == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

//--- files.f
+incdir+bench
src/fdc_pkg.sv
src/fdc_host_port.sv
src/fdc_cmd_fsm.sv
src/fdc_step_timer.sv
src/fdc_drive_track.sv
src/fdc_top.sv
bench/fdc_tb.sv
